// File: sim.f
lcd_pkg.sv
lcd_timing.sv
lcd_stat_irq.sv
lcd_vram_oam.sv
lcd_apb_regs.sv
lcd_ppu_top.sv
tb_lcd_ppu.sv

// File: Makefile
# Verilator flow for the LCD timing and register core

TOP := tb_lcd_ppu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o sim_lcd
	@out="$$(./obj_dir/sim_lcd)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// File: tb_lcd_ppu.sv
`timescale 1ns/10ps

module tb_lcd_ppu
  import lcd_pkg::*;
;

  // ========================================
  // Short timing and table layout
  // ========================================

  localparam int LINES   = 10;
  localparam int VISIBLE = 6;
  localparam int FRAME   = 200;

  // Mode field of STAT
  localparam logic [1:0] M_HBLANK = 2'd0;
  localparam logic [1:0] M_VBLANK = 2'd1;
  localparam logic [1:0] M_OAM    = 2'd2;
  localparam logic [1:0] M_PIXEL  = 2'd3;

  // Row operations
  localparam logic [1:0] OP_WR   = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_POLL = 2'd2;
  // Write of the inverted shadow byte
  localparam logic [1:0] OP_WRX  = 2'd3;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pslverr;
  logic        vblank_irq;
  logic        stat_irq;

  // Stimulus table
  logic [1:0]  t_op   [0:79];
  logic [15:0] t_addr [0:79];
  logic [7:0]  t_data [0:79];
  logic [7:0]  t_exp  [0:79];
  logic        t_err  [0:79];
  int          t_sh   [0:79];
  int          n_rows;
  logic        table_ready;

  // RAM contents the DUT should hold
  logic [7:0]  shadow [0:7];
  logic [31:0] lfsr;

  int data_errors;
  int err_errors;
  int seq_errors;
  int vbl_count;
  int stat_count;
  logic vbl_pending;

  lcd_ppu_top #(
    .DOTS_PER_LINE(9'd20), .LINES_PER_FRAME(8'd10), .VISIBLE_LINES(8'd6),
    .OAM_SCAN_DOTS(9'd4), .PIXEL_DOTS(9'd8)
  ) lcd_ppu_top_i (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pslverr(pslverr),
    .vblank_irq(vblank_irq), .stat_irq(stat_irq)
  );

  always #2 clk = ~clk;

  // Pulse counters, value seen just before each edge
  always @(posedge clk) begin
    if (vblank_irq) begin
      vbl_count   <= vbl_count + 1;
      vbl_pending <= 1'b1;
    end
    if (stat_irq) begin
      stat_count <= stat_count + 1;
    end
  end

  // ========================================
  // Helpers
  // ========================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    b = 8'h00;
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  // Legal next mode seen by a STAT sample
  function automatic bit mode_follows(input logic [1:0] prev, input logic [1:0] cur);
    if (cur == prev) return 1'b1;
    case (prev)
      M_OAM:    return cur == M_PIXEL;
      M_PIXEL:  return cur == M_HBLANK;
      M_HBLANK: return (cur == M_OAM) || (cur == M_VBLANK);
      default:  return cur == M_OAM;
    endcase
  endfunction

  task automatic add_row(input logic [1:0] op, input logic [15:0] addr,
                         input logic [7:0] data, input logic [7:0] expd,
                         input logic experr, input int sh);
    t_op[n_rows]   = op;
    t_addr[n_rows] = addr;
    t_data[n_rows] = data;
    t_exp[n_rows]  = expd;
    t_err[n_rows]  = experr;
    t_sh[n_rows]   = sh;
    n_rows++;
  endtask

  // One APB transfer, back to back with the next one
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
                          output logic [7:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    // Mid access phase
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_data(input logic [15:0] addr, input logic [7:0] got,
                            input logic [7:0] expd);
    assert (got == expd) else begin
      data_errors++;
      $display("Error: %0t ns: read of 0x%04h gave 0x%02h, expected 0x%02h",
               $time, addr, got, expd);
    end
  endtask

  task automatic check_err(input logic [15:0] addr, input logic got, input logic expd);
    assert (got == expd) else begin
      err_errors++;
      $display("Error: %0t ns: pslverr for 0x%04h was %0b, expected %0b",
               $time, addr, got, expd);
    end
  endtask

  // Leave the mode first so the poll ends right at its entry
  task automatic poll_mode(input logic [1:0] m);
    logic [7:0] rd;
    logic       er;
    bit         left;
    bit         done;
    int         tries;
    left  = 1'b0;
    done  = 1'b0;
    tries = 0;
    while (!done && tries < 500) begin
      apb_xfer(1'b0, REG_STAT, 8'h00, rd, er);
      tries++;
      if (rd[1:0] != m) left = 1'b1;
      else if (left) done = 1'b1;
    end
    assert (done) else begin
      seq_errors++;
      $display("Polling STAT for mode %0d gave up after %0d reads", m, tries);
    end
  endtask

  task automatic run_row(input int i);
    logic [7:0] wd;
    logic [7:0] ex;
    logic [7:0] rd;
    logic       er;
    wd = t_data[i];
    ex = t_exp[i];
    if (t_sh[i] >= 0) begin
      ex = shadow[t_sh[i]];
      wd = (t_op[i] == OP_WRX) ? ~shadow[t_sh[i]] : shadow[t_sh[i]];
    end
    if (t_op[i] == OP_POLL) begin
      poll_mode(t_data[i][1:0]);
    end else begin
      apb_xfer(t_op[i] != OP_RD, t_addr[i], wd, rd, er);
      if (t_op[i] == OP_RD) check_data(t_addr[i], rd, ex);
      check_err(t_addr[i], er, t_err[i]);
    end
  endtask

  // ========================================
  // Table
  // ========================================

  task automatic build_table();
    // Reset values, LY=LYC=0 gives coincidence
    add_row(OP_RD, REG_LCDC, 8'h00, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_STAT, 8'h00, 8'h84, 1'b0, -1);
    // Register file with LCD still off
    add_row(OP_WR, REG_LCDC, 8'h11, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_LCDC, 8'h00, 8'h11, 1'b0, -1);
    add_row(OP_WR, REG_SCY,  8'h5A, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_SCY,  8'h00, 8'h5A, 1'b0, -1);
    add_row(OP_WR, REG_SCX,  8'hA5, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_SCX,  8'h00, 8'hA5, 1'b0, -1);
    add_row(OP_WR, REG_BGP,  8'hE4, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_BGP,  8'h00, 8'hE4, 1'b0, -1);
    add_row(OP_WR, REG_LYC,  8'h3C, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_LYC,  8'h00, 8'h3C, 1'b0, -1);
    // Only bits 6:3 stick, bit 7 always set
    add_row(OP_WR, REG_STAT, 8'hFF, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_STAT, 8'h00, 8'hF8, 1'b0, -1);
    add_row(OP_WR, REG_STAT, 8'h00, 8'h00, 1'b0, -1);
    add_row(OP_RD, REG_STAT, 8'h00, 8'h80, 1'b0, -1);
    // LY is read only
    add_row(OP_WR, REG_LY,   8'h55, 8'h00, 1'b1, -1);
    add_row(OP_RD, REG_LY,   8'h00, 8'h00, 1'b0, -1);
    // Unmapped space
    add_row(OP_RD, 16'hFF46, 8'h00, 8'hFF, 1'b1, -1);
    add_row(OP_RD, 16'hFF4F, 8'h00, 8'hFF, 1'b1, -1);
    add_row(OP_RD, 16'hA000, 8'h00, 8'hFF, 1'b1, -1);
    add_row(OP_WR, 16'h0000, 8'h12, 8'h00, 1'b1, -1);
    // Memory with the LCD off
    add_row(OP_WR, 16'h8000, 8'h00, 8'h00, 1'b0, 0);
    add_row(OP_WR, 16'h9FFF, 8'h00, 8'h00, 1'b0, 1);
    add_row(OP_WR, 16'h8123, 8'h00, 8'h00, 1'b0, 2);
    add_row(OP_WR, 16'hFE00, 8'h00, 8'h00, 1'b0, 3);
    add_row(OP_WR, 16'hFE9F, 8'h00, 8'h00, 1'b0, 4);
    add_row(OP_WR, 16'hFE50, 8'h00, 8'h00, 1'b0, 5);
    add_row(OP_RD, 16'h8000, 8'h00, 8'h00, 1'b0, 0);
    add_row(OP_RD, 16'h9FFF, 8'h00, 8'h00, 1'b0, 1);
    add_row(OP_RD, 16'h8123, 8'h00, 8'h00, 1'b0, 2);
    add_row(OP_RD, 16'hFE00, 8'h00, 8'h00, 1'b0, 3);
    add_row(OP_RD, 16'hFE9F, 8'h00, 8'h00, 1'b0, 4);
    add_row(OP_RD, 16'hFE50, 8'h00, 8'h00, 1'b0, 5);
    // Display on, pixel transfer blocks both arrays
    add_row(OP_WR, REG_LCDC, 8'h80, 8'h00, 1'b0, -1);
    add_row(OP_POLL, 16'h0000, {6'd0, M_PIXEL}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'h8000, 8'h00, 8'hFF, 1'b1, -1);
    add_row(OP_POLL, 16'h0000, {6'd0, M_PIXEL}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'hFE00, 8'h00, 8'hFF, 1'b1, -1);
    add_row(OP_POLL, 16'h0000, {6'd0, M_PIXEL}, 8'h00, 1'b0, -1);
    add_row(OP_WRX, 16'h8000, 8'h00, 8'h00, 1'b1, 0);
    add_row(OP_POLL, 16'h0000, {6'd0, M_PIXEL}, 8'h00, 1'b0, -1);
    add_row(OP_WRX, 16'hFE00, 8'h00, 8'h00, 1'b1, 3);
    // Dropped writes left the old bytes
    add_row(OP_POLL, 16'h0000, {6'd0, M_HBLANK}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'h8000, 8'h00, 8'h00, 1'b0, 0);
    add_row(OP_POLL, 16'h0000, {6'd0, M_HBLANK}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'hFE00, 8'h00, 8'h00, 1'b0, 3);
    // OAM scan blocks OAM only
    add_row(OP_POLL, 16'h0000, {6'd0, M_OAM}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'hFE00, 8'h00, 8'hFF, 1'b1, -1);
    add_row(OP_POLL, 16'h0000, {6'd0, M_OAM}, 8'h00, 1'b0, -1);
    add_row(OP_WRX, 16'hFE50, 8'h00, 8'h00, 1'b1, 5);
    add_row(OP_POLL, 16'h0000, {6'd0, M_OAM}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'h8123, 8'h00, 8'h00, 1'b0, 2);
    add_row(OP_POLL, 16'h0000, {6'd0, M_HBLANK}, 8'h00, 1'b0, -1);
    add_row(OP_RD, 16'hFE50, 8'h00, 8'h00, 1'b0, 5);
  endtask

  // 150 rounds of two transfers span three frames
  task automatic count_window(output int vbl_d, output int stat_d);
    logic [7:0] rd;
    logic       er;
    int         v0;
    int         s0;
    v0 = vbl_count;
    s0 = stat_count;
    repeat (150) begin
      apb_xfer(1'b0, REG_LY, 8'h00, rd, er);
      apb_xfer(1'b0, REG_LY, 8'h00, rd, er);
    end
    vbl_d  = vbl_count - v0;
    stat_d = stat_count - s0;
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin
    logic [7:0] rd;
    logic [7:0] ly_s;
    logic [7:0] ly_prev;
    logic [1:0] m_prev;
    logic       er;
    bit         have_prev;
    int         v0;
    int         vbl_d;
    int         stat_d;
    clk = 1'b0;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 16'h0000;
    pwdata = 8'h00;
    data_errors = 0;
    err_errors = 0;
    seq_errors = 0;
    vbl_count = 0;
    stat_count = 0;
    vbl_pending = 1'b0;
    n_rows = 0;
    table_ready = 1'b0;
    lfsr = 32'h2950_1a45;
    for (int k = 0; k < 8; k++) begin
      rand_byte(shadow[k]);
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end

    // Line order, mode order and VBlank pulses over three frames
    have_prev = 1'b0;
    ly_prev = 8'd0;
    m_prev = M_HBLANK;
    v0 = vbl_count;
    vbl_pending <= 1'b0;
    repeat (150) begin
      apb_xfer(1'b0, REG_LY, 8'h00, ly_s, er);
      if (vbl_pending) begin
        assert (ly_s >= 8'(VISIBLE)) else begin
          seq_errors++;
          $display("Error: %0t ns: LY %0d read after VBlank request", $time, ly_s);
        end
        vbl_pending <= 1'b0;
      end
      apb_xfer(1'b0, REG_STAT, 8'h00, rd, er);
      assert (ly_s < 8'(LINES)) else begin
        seq_errors++;
        $display("Error: %0t ns: LY %0d beyond the frame", $time, ly_s);
      end
      if (have_prev) begin
        assert ((ly_s == ly_prev) || (ly_s == ly_prev + 8'd1) ||
                (ly_s == 8'd0 && ly_prev == 8'(LINES - 1))) else begin
          seq_errors++;
          $display("Error: %0t ns: LY went from %0d to %0d", $time, ly_prev, ly_s);
        end
        assert (mode_follows(m_prev, rd[1:0])) else begin
          seq_errors++;
          $display("Error: %0t ns: mode %0d after mode %0d", $time, rd[1:0], m_prev);
        end
      end
      // LY was taken two clocks before the mode
      if (rd[1:0] == M_VBLANK) begin
        assert (ly_s >= 8'(VISIBLE - 1)) else begin
          seq_errors++;
          $display("Error: %0t ns: VBlank mode on line %0d", $time, ly_s);
        end
      end else begin
        assert (ly_s < 8'(VISIBLE) || ly_s == 8'(LINES - 1)) else begin
          seq_errors++;
          $display("Error: %0t ns: mode %0d on line %0d", $time, rd[1:0], ly_s);
        end
      end
      ly_prev = ly_s;
      m_prev = rd[1:0];
      have_prev = 1'b1;
    end
    vbl_d = vbl_count - v0;
    assert (vbl_d == 3) else begin
      seq_errors++;
      $display("Error: %0t ns: %0d VBlank requests in three frames", $time, vbl_d);
    end

    // LYC source alone, matching line 3
    apb_xfer(1'b1, REG_STAT, 8'h40, rd, er);
    apb_xfer(1'b1, REG_LYC, 8'h03, rd, er);
    repeat (3) apb_xfer(1'b0, REG_LY, 8'h00, rd, er);
    count_window(vbl_d, stat_d);
    assert (stat_d == 3) else begin
      seq_errors++;
      $display("Error: %0t ns: %0d STAT requests with LYC=3", $time, stat_d);
    end
    assert (vbl_d == 3) else begin
      seq_errors++;
      $display("Error: %0t ns: %0d VBlank requests in three frames", $time, vbl_d);
    end

    // No sources, no requests
    apb_xfer(1'b1, REG_STAT, 8'h00, rd, er);
    repeat (3) apb_xfer(1'b0, REG_LY, 8'h00, rd, er);
    count_window(vbl_d, stat_d);
    assert (stat_d == 0) else begin
      seq_errors++;
      $display("Error: %0t ns: %0d STAT requests with no enables", $time, stat_d);
    end
    assert (vbl_d == 3) else begin
      seq_errors++;
      $display("Error: %0t ns: %0d VBlank requests in three frames", $time, vbl_d);
    end
    bus_idle();

    $display("Checks done: %0d data errors, %0d pslverr errors, %0d sequence errors",
             data_errors, err_errors, seq_errors);
    if (data_errors + err_errors + seq_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // ========================================
  // Watchdog
  // ========================================

  initial begin
    int limit;
    wait (table_ready);
    // Rows, four frames of polling slack, three count windows
    limit = n_rows * 50 + 4 * FRAME + 3 * 3 * FRAME;
    #(limit * 4);
    $display("Run did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: lcd_ppu_top.sv
`timescale 1ns/10ps

module lcd_ppu_top
  import lcd_pkg::*;
#(
  parameter logic [8:0] DOTS_PER_LINE   = 9'd456,
  parameter logic [7:0] LINES_PER_FRAME = 8'd154,
  parameter logic [7:0] VISIBLE_LINES   = 8'd144,
  parameter logic [8:0] OAM_SCAN_DOTS   = 9'd80,
  parameter logic [8:0] PIXEL_DOTS      = 9'd172
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [15:0] paddr,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       pslverr,
  output logic       vblank_irq,
  output logic       stat_irq
);

  // Register file to timing and interrupts
  logic       lcd_on;
  logic [7:0] lyc;
  logic [3:0] stat_ie;

  // Timing outputs
  logic [7:0] ly;
  lcd_mode_t  mode;
  logic       vblank_start;

  logic       coincidence;

  // Memory port
  logic        mem_req;
  logic        mem_we;
  logic [15:0] mem_addr;
  logic [7:0]  mem_wdata;
  logic [7:0]  mem_rdata;
  logic        mem_blocked;

  // ========================================
  // Bus and registers
  // ========================================

  lcd_apb_regs lcd_apb_regs_i (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pslverr(pslverr),
    .ly(ly), .mode(mode), .coincidence(coincidence),
    .mem_rdata(mem_rdata), .mem_blocked(mem_blocked),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .lcd_on(lcd_on), .lyc(lyc), .stat_ie(stat_ie)
  );

  // ========================================
  // Timing, interrupts and memory
  // ========================================

  lcd_timing #(
    .DOTS_PER_LINE(DOTS_PER_LINE), .LINES_PER_FRAME(LINES_PER_FRAME),
    .VISIBLE_LINES(VISIBLE_LINES), .OAM_SCAN_DOTS(OAM_SCAN_DOTS), .PIXEL_DOTS(PIXEL_DOTS)
  ) lcd_timing_i (
    .clk(clk), .reset(reset), .lcd_on(lcd_on),
    .ly(ly), .mode(mode), .vblank_start(vblank_start)
  );

  lcd_stat_irq lcd_stat_irq_i (
    .clk(clk), .reset(reset), .ly(ly), .lyc(lyc), .mode(mode), .stat_ie(stat_ie),
    .vblank_start(vblank_start), .coincidence(coincidence),
    .vblank_irq(vblank_irq), .stat_irq(stat_irq)
  );

  lcd_vram_oam lcd_vram_oam_i (
    .clk(clk), .reset(reset), .mode(mode),
    .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata), .mem_blocked(mem_blocked)
  );

endmodule

// File: lcd_apb_regs.sv
`timescale 1ns/10ps

module lcd_apb_regs
  import lcd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // APB slave
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [15:0] paddr,
  input  logic [7:0] pwdata,
  output logic [7:0] prdata,
  output logic       pslverr,
  // Timing and interrupt status
  input  logic [7:0] ly,
  input  lcd_mode_t  mode,
  input  logic       coincidence,
  // Memory port
  input  logic [7:0] mem_rdata,
  input  logic       mem_blocked,
  output logic       mem_req,
  output logic       mem_we,
  output logic [15:0] mem_addr,
  output logic [7:0] mem_wdata,
  // Control out
  output logic       lcd_on,
  output logic [7:0] lyc,
  output logic [3:0] stat_ie
);

  // LCD register file
  logic [7:0] lcdc;
  logic [7:0] scy;
  logic [7:0] scx;
  logic [7:0] bgp;

  // Bus phases
  logic setup;
  logic access;
  logic wr_en;

  // Address lands in VRAM or OAM
  logic in_mem;

  // Blocking seen when the read was issued
  logic rd_blocked_q;

  // Error before gating by the access phase
  logic err;

  assign setup  = psel && !penable;
  assign access = psel && penable;
  assign wr_en  = access && pwrite;
  assign in_mem = is_vram(paddr) || is_oam(paddr);

  // ========================================
  // Memory port
  // ========================================

  // Reads issue in setup so data is ready for the access phase
  // Writes commit at the end of the access phase
  assign mem_req   = psel && in_mem && (penable ? pwrite : !pwrite);
  assign mem_we    = pwrite;
  assign mem_addr  = paddr;
  assign mem_wdata = pwdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_blocked_q <= 1'b0;
    end else if (setup) begin
      rd_blocked_q <= mem_blocked;
    end
  end

  // ========================================
  // Register writes
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc    <= 8'h00;
      stat_ie <= 4'h0;
      scy     <= 8'h00;
      scx     <= 8'h00;
      lyc     <= 8'h00;
      bgp     <= 8'h00;
    end else if (wr_en) begin
      case (paddr)
        REG_LCDC: lcdc <= pwdata;
        // Only the enable bits are writable
        REG_STAT: stat_ie <= pwdata[STAT_LYC_IE:STAT_HBL_IE];
        REG_SCY:  scy <= pwdata;
        REG_SCX:  scx <= pwdata;
        REG_LYC:  lyc <= pwdata;
        REG_BGP:  bgp <= pwdata;
        default: ;
      endcase
    end
  end

  assign lcd_on = lcdc[LCDC_ON];

  // ========================================
  // Read data and error
  // ========================================

  always_comb begin
    prdata = 8'hFF;
    err    = 1'b0;
    if (in_mem) begin
      // Blocked reads already return 0xFF from the memory
      prdata = mem_rdata;
      err    = pwrite ? mem_blocked : rd_blocked_q;
    end else begin
      case (paddr)
        REG_LCDC: prdata = lcdc;
        REG_STAT: prdata = {1'b1, stat_ie, coincidence, mode};
        REG_SCY:  prdata = scy;
        REG_SCX:  prdata = scx;
        REG_LY: begin
          prdata = ly;
          // LY is read only
          err    = pwrite;
        end
        REG_LYC:  prdata = lyc;
        REG_BGP:  prdata = bgp;
        default: begin
          // Unmapped
          prdata = 8'hFF;
          err    = 1'b1;
        end
      endcase
    end
  end

  assign pslverr = access && err;

  // Access phase only inside a selected transfer
  a_penable_psel : assert property (@(posedge clk) disable iff (reset)
    penable |-> psel);

endmodule

// File: lcd_vram_oam.sv
`timescale 1ns/10ps

module lcd_vram_oam
  import lcd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  lcd_mode_t  mode,
  input  logic       mem_req,
  input  logic       mem_we,
  input  logic [15:0] mem_addr,
  input  logic [7:0] mem_wdata,
  output logic [7:0] mem_rdata,
  output logic       mem_blocked
);

  // Backing arrays
  logic [7:0] vram [0:VRAM_BYTES-1];
  logic [7:0] oam  [0:OAM_BYTES-1];

  // Window hits for the current address
  logic in_vram;
  logic in_oam;

  // Array offsets, both windows are aligned
  logic [12:0] vram_idx;
  logic [7:0]  oam_idx;

  logic rd_en;
  logic wr_en;

  assign in_vram  = is_vram(mem_addr);
  assign in_oam   = is_oam(mem_addr);
  assign vram_idx = mem_addr[12:0];
  assign oam_idx  = mem_addr[7:0];

  // ========================================
  // Access blocking
  // ========================================

  // Pixel transfer owns VRAM
  // OAM scan and pixel transfer both own OAM
  always_comb begin
    mem_blocked = 1'b0;
    if (in_vram && (mode == LCD_PIXEL)) begin
      mem_blocked = 1'b1;
    end
    if (in_oam && ((mode == LCD_OAM_SCAN) || (mode == LCD_PIXEL))) begin
      mem_blocked = 1'b1;
    end
  end

  assign rd_en = mem_req && !mem_we;
  assign wr_en = mem_req && mem_we && !mem_blocked;

  // ========================================
  // Write port
  // ========================================

  // Blocked writes fall through silently
  always_ff @(posedge clk) begin
    if (wr_en && in_vram) begin
      vram[vram_idx] <= mem_wdata;
    end
    if (wr_en && in_oam) begin
      oam[oam_idx] <= mem_wdata;
    end
  end

  // ========================================
  // Read port
  // ========================================

  // Registered read, held until the next request
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_rdata <= 8'hFF;
    end else if (rd_en) begin
      if (mem_blocked) begin
        mem_rdata <= 8'hFF;
      end else if (in_vram) begin
        mem_rdata <= vram[vram_idx];
      end else if (in_oam) begin
        mem_rdata <= oam[oam_idx];
      end else begin
        mem_rdata <= 8'hFF;
      end
    end
  end

endmodule

// File: lcd_stat_irq.sv
`timescale 1ns/10ps

module lcd_stat_irq
  import lcd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] ly,
  input  logic [7:0] lyc,
  input  lcd_mode_t  mode,
  input  logic [3:0] stat_ie,
  input  logic       vblank_start,
  output logic       coincidence,
  output logic       vblank_irq,
  output logic       stat_irq
);

  // stat_ie holds STAT bits 6:3
  localparam int IE_LYC = STAT_LYC_IE - STAT_HBL_IE;
  localparam int IE_OAM = STAT_OAM_IE - STAT_HBL_IE;
  localparam int IE_VBL = STAT_VBL_IE - STAT_HBL_IE;
  localparam int IE_HBL = 0;

  // Combined STAT request line and its previous value
  logic stat_line;
  logic stat_line_q;

  // ========================================
  // Sources
  // ========================================

  // Any enabled source keeps the line high
  assign stat_line = (stat_ie[IE_LYC] && coincidence) ||
                     (stat_ie[IE_OAM] && (mode == LCD_OAM_SCAN)) ||
                     (stat_ie[IE_VBL] && (mode == LCD_VBLANK)) ||
                     (stat_ie[IE_HBL] && (mode == LCD_HBLANK));

  // ========================================
  // Request pulses
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      coincidence <= 1'b0;
      stat_line_q <= 1'b0;
      stat_irq    <= 1'b0;
      vblank_irq  <= 1'b0;
    end else begin
      // Compared on the current line
      coincidence <= (ly == lyc);
      stat_line_q <= stat_line;
      // Rising edge only, so overlapping sources give one request
      stat_irq    <= stat_line && !stat_line_q;
      vblank_irq  <= vblank_start;
    end
  end

  // One request per edge of the shared line
  a_stat_pulse : assert property (@(posedge clk) disable iff (reset)
    stat_irq |=> !stat_irq);

endmodule

// File: lcd_timing.sv
`timescale 1ns/10ps

module lcd_timing
  import lcd_pkg::*;
#(
  parameter logic [8:0] DOTS_PER_LINE   = 9'd456,
  parameter logic [7:0] LINES_PER_FRAME = 8'd154,
  parameter logic [7:0] VISIBLE_LINES   = 8'd144,
  parameter logic [8:0] OAM_SCAN_DOTS   = 9'd80,
  parameter logic [8:0] PIXEL_DOTS      = 9'd172
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      lcd_on,
  output logic [7:0] ly,
  output lcd_mode_t mode,
  output logic      vblank_start
);

  // First dot of HBlank on a visible line
  localparam logic [8:0] PIXEL_END = OAM_SCAN_DOTS + PIXEL_DOTS;
  localparam logic [8:0] LAST_DOT  = DOTS_PER_LINE - 9'd1;
  localparam logic [7:0] LAST_LINE = LINES_PER_FRAME - 8'd1;

  // Dot position within the current line
  logic [8:0] dot_cnt;
  logic       line_end;

  assign line_end = (dot_cnt == LAST_DOT);

  // ========================================
  // Dot and line counters
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot_cnt <= 9'd0;
      ly      <= 8'd0;
    end else if (!lcd_on) begin
      // Display off parks the beam at the top left
      dot_cnt <= 9'd0;
      ly      <= 8'd0;
    end else if (line_end) begin
      dot_cnt <= 9'd0;
      // Last line of the frame wraps to line 0
      if (ly == LAST_LINE) begin
        ly <= 8'd0;
      end else begin
        ly <= ly + 8'd1;
      end
    end else begin
      dot_cnt <= dot_cnt + 9'd1;
    end
  end

  // ========================================
  // VBlank entry
  // ========================================

  // High on the same clock that ly steps to the first blank line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vblank_start <= 1'b0;
    end else begin
      vblank_start <= lcd_on && line_end && (ly == VISIBLE_LINES - 8'd1);
    end
  end

  // ========================================
  // Mode decode
  // ========================================

  always_comb begin
    if (!lcd_on) begin
      mode = LCD_HBLANK;
    end else if (ly >= VISIBLE_LINES) begin
      mode = LCD_VBLANK;
    end else if (dot_cnt < OAM_SCAN_DOTS) begin
      mode = LCD_OAM_SCAN;
    end else if (dot_cnt < PIXEL_END) begin
      mode = LCD_PIXEL;
    end else begin
      // Rest of the visible line
      mode = LCD_HBLANK;
    end
  end

  // Line counter never leaves the frame
  a_ly_range : assert property (@(posedge clk) disable iff (reset)
    ly < LINES_PER_FRAME);

  // Display on restarts at the top of the frame with OAM scan
  a_on_restart : assert property (@(posedge clk) disable iff (reset)
    $rose(lcd_on) |-> (ly == 8'd0) && (mode == LCD_OAM_SCAN));

endmodule

// File: lcd_pkg.sv
package lcd_pkg;

  // ========================================
  // Display mode
  // ========================================

  // Encoding matches the STAT mode field
  typedef enum logic [1:0] {
    LCD_HBLANK   = 2'd0,
    LCD_VBLANK   = 2'd1,
    LCD_OAM_SCAN = 2'd2,
    LCD_PIXEL    = 2'd3
  } lcd_mode_t;

  // ========================================
  // Address map
  // ========================================

  // Video RAM window, 8 KB
  localparam logic [15:0] VRAM_BASE = 16'h8000;
  localparam logic [15:0] VRAM_LAST = 16'h9FFF;
  localparam int VRAM_BYTES = 8192;

  // Object attribute memory, 40 entries of 4 bytes
  localparam logic [15:0] OAM_BASE = 16'hFE00;
  localparam logic [15:0] OAM_LAST = 16'hFE9F;
  localparam int OAM_BYTES = 160;

  // LCD registers
  localparam logic [15:0] REG_LCDC = 16'hFF40;
  localparam logic [15:0] REG_STAT = 16'hFF41;
  localparam logic [15:0] REG_SCY  = 16'hFF42;
  localparam logic [15:0] REG_SCX  = 16'hFF43;
  localparam logic [15:0] REG_LY   = 16'hFF44;
  localparam logic [15:0] REG_LYC  = 16'hFF45;
  localparam logic [15:0] REG_BGP  = 16'hFF47;

  // STAT interrupt enable bits
  localparam int STAT_LYC_IE = 6;
  localparam int STAT_OAM_IE = 5;
  localparam int STAT_VBL_IE = 4;
  localparam int STAT_HBL_IE = 3;

  // LCDC display enable
  localparam int LCDC_ON = 7;

  // Window hit tests
  function automatic logic is_vram(input logic [15:0] addr);
    return (addr >= VRAM_BASE) && (addr <= VRAM_LAST);
  endfunction

  function automatic logic is_oam(input logic [15:0] addr);
    return (addr >= OAM_BASE) && (addr <= OAM_LAST);
  endfunction

endpackage
